/* verification/space_bg_patterns.txt */
// Columns, all hex: frame index, pixel x, pixel y, active flag, expected r, g, b
// Frame index counts rising vsync edges after reset release and ends with an ffff line
0 c4 c4 1 3 1 0      // star 1 over halo1 at frame 0
1 174 141 1 0 0 0    // star 7 dark
2 2e6 1bc 1 0 0 0    // star 6 dark
3 395 228 1 0 0 0    // star 5 dark
4 2cf 10b 1 0 0 0    // star 4 dark
5 262 176 1 0 0 0    // star 3 dark
6 19c 8e 1 0 0 0     // star 2 dark
7 b3 c4 1 1 0 0      // star 1 dark, halo1 behind it
8 b0 c4 1 3 1 0      // star 1 back
9 259 177 1 3 3 3    // star 3 corner pixel
a 2c0 10b 1 3 1 0    // star 4 shifted by 25
b 2d2 1bc 1 0 0 0    // two pixels right of star 6
c 2cc 1bb 1 3 3 3
d 18b 8f 1 1 2 3     // star 2 edge, blue class
e 153 143 1 0 0 0    // two pixels below star 7
f 377 228 1 1 2 3
10 50 50 1 3 2 0     // sun centre
11 c8 50 1 2 1 0     // corona
12 e6 50 1 1 0 0     // halo1
13 136 50 1 1 0 1    // halo2
14 151 50 1 0 0 0    // just past halo2
15 c1 50 1 2 1 0     // just past the sun disc
16 b4 12c 1 3 1 0    // hot planet lit half
17 cd 154 1 3 0 0    // hot planet dark half
18 90 12c 1 1 0 1    // just outside hot planet, halo2
19 1e0 e0 1 0 1 0    // earth land
1a 1e0 c8 1 0 1 3    // earth ocean
1b 221 e0 1 0 0 0    // just outside earth
1c 3a0 80 1 0 2 2    // ice band
1d 3a0 a8 1 0 1 1    // ice dark band
1e 35f 80 1 0 0 0    // just outside ice planet
1f 1e0 e0 0 0 0 0    // blanked over the earth
28 20a 176 1 3 3 3   // star 3 shifted by 100
29 3e2 59 1 3 3 3    // star 0 wrapped to x 994
2a 3e2 59 1 0 0 0    // star 0 has moved on to x 991
ffff 0 0 0 0 0 0

/* sources.f */
hdl/space_bg_pkg.sv
hdl/body_region_decode.sv
hdl/star_field.sv
hdl/color_compose.sv
hdl/space_bg_top.sv
verification/space_bg_chk.sv
verification/space_bg_tb.sv

/* verification/space_bg_tb.sv */
// Testbench for the space background: pattern replay, compare tasks and timeout
`default_nettype none
`timescale 1ns/1ns

module space_bg_tb import space_bg_pkg::*; ();

    // Seven hex words per pattern line
    localparam int FIELDS    = 7;
    localparam int MAX_LINES = 64;

    logic        vsync;
    logic        rst_n;
    logic        video_active;
    coord_t      pix_x;
    coord_t      pix_y;
    chan_t       r;
    chan_t       g;
    chan_t       b;

    logic [15:0] pattern_words [MAX_LINES * FIELDS];

    int          line_count;
    int          max_frame;
    int          edge_count;
    int          next_line;
    int          line_index;
    int          frame;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    space_bg_top uut (
        .vsync        (vsync),
        .rst_n        (rst_n),
        .video_active (video_active),
        .pix_x        (pix_x),
        .pix_y        (pix_y),
        .r            (r),
        .g            (g),
        .b            (b)
    );

    always #10 vsync = ~vsync;

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_chan(input string name, input chan_t expected, input chan_t actual);
        if (actual !== expected) begin
            $display("error %s: expected %h got %h (line %0d, x %0d, y %0d, frame %0d)",
                     name, expected, actual, line_index, pix_x, pix_y, edge_count);
            stop_on_failure("colour mismatch on a pattern line");
        end
    endtask

    task automatic check_blank(input chan_t rv, input chan_t gv, input chan_t bv);
        if ({rv, gv, bv} !== 6'd0) begin
            $display("error rgb while blanked: expected %h %h %h got %h %h %h (x %0d, y %0d)",
                     2'd0, 2'd0, 2'd0, rv, gv, bv, pix_x, pix_y);
            stop_on_failure("colour output not black during blanking");
        end
    endtask

    // Idle cycles carry a random pixel with video_active low
    task automatic drive_blank_pixel();
        video_active <= 1'b0;
        pix_x        <= coord_t'($urandom_range(H_RES - 1));
        pix_y        <= coord_t'($urandom_range(V_RES - 1));
    endtask

    task automatic apply_line(input int idx);
        int base;
        base = idx * FIELDS;
        video_active <= pattern_words[base + 3][0];
        pix_x        <= coord_t'(pattern_words[base + 1]);
        pix_y        <= coord_t'(pattern_words[base + 2]);
    endtask

    task automatic compare_line(input int idx);
        int base;
        base       = idx * FIELDS;
        line_index = idx;
        check_chan("r", chan_t'(pattern_words[base + 4]), r);
        check_chan("g", chan_t'(pattern_words[base + 5]), g);
        check_chan("b", chan_t'(pattern_words[base + 6]), b);
    endtask

    // Run limit follows the length of the replay
    always @(posedge vsync) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: pattern replay did not finish within %0d cycles", cycle_limit);
            stop_on_failure("simulation stopped by the cycle limit");
        end
    end

    always @(uut.u_compose.chk.failures) begin
        if (uut.u_compose.chk.failures > 0) begin
            stop_on_failure("a bound assertion on the colour stage failed");
        end
    end

    initial begin
        vsync        = 1'b0;
        rst_n        = 1'b0;
        video_active = 1'b0;
        pix_x        = '0;
        pix_y        = '0;
        void'($urandom(32'h8ed0_2224));

        $readmemh("verification/space_bg_patterns.txt", pattern_words);

        // End marker is a frame index of ffff
        line_count = 0;
        max_frame  = 0;
        while (line_count < MAX_LINES &&
               !$isunknown(pattern_words[line_count * FIELDS]) &&
               pattern_words[line_count * FIELDS] != 16'hffff) begin
            if (pattern_words[line_count * FIELDS] > max_frame) begin
                max_frame = pattern_words[line_count * FIELDS];
            end
            line_count++;
        end
        if (line_count == 0) begin
            stop_on_failure("no pattern lines were loaded from the pattern file");
        end
        cycle_limit = max_frame + line_count + 50;

        repeat (5) begin
            @(posedge vsync);
            drive_blank_pixel();
            @(negedge vsync);
            check_blank(r, g, b);
        end

        // Counters hold at zero through the release edge, which is frame 0
        @(posedge vsync);
        rst_n <= 1'b1;
        edge_count = 0;

        next_line = 0;
        while (next_line < line_count) begin
            frame = pattern_words[next_line * FIELDS];
            if (frame < edge_count) begin
                $display("pattern line %0d asks for frame %0d, which has already passed",
                         next_line, frame);
                stop_on_failure("pattern file frame order is broken");
            end
            if (frame == edge_count) begin
                apply_line(next_line);
                @(negedge vsync);
                compare_line(next_line);
                next_line++;
            end else begin
                drive_blank_pixel();
                @(negedge vsync);
                check_blank(r, g, b);
            end
            if (next_line < line_count) begin
                @(posedge vsync);
                edge_count++;
            end
        end

        // Assertions on the last pixel settle before the verdict
        @(posedge vsync);
        if (uut.u_compose.chk.failures == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            stop_on_failure("a bound assertion on the colour stage failed");
        end
    end

endmodule

`default_nettype wire

/* verification/space_bg_chk.sv */
// Bound assertions on the colour stage: blanking, known outputs, stars behind discs
`default_nettype none
`timescale 1ns/1ns

module space_bg_chk import space_bg_pkg::*; (
    input logic        vsync,
    input logic        rst_n,
    input logic        video_active,
    input logic        in_sun,
    input logic        in_corona,
    input logic        in_p1,
    input logic        in_p2,
    input logic        in_p4,
    input logic        star_hit,
    input star_class_t star_class,
    input chan_t       r,
    input chan_t       g,
    input chan_t       b
);

    logic [5:0] star_rgb;
    logic       disc_any;
    int         failures = 0;

    always_comb begin
        case (star_class)
            2'd0:    star_rgb = 6'b11_11_11;
            2'd1:    star_rgb = 6'b11_01_00;
            default: star_rgb = 6'b01_10_11;
        endcase
    end

    assign disc_any = in_sun | in_corona | in_p1 | in_p2 | in_p4;

    a_blank: assert property (@(negedge vsync) !video_active |-> ({r, g, b} == 6'd0))
        else begin
            $error("colour output is not black while video_active is low");
            failures++;
        end

    a_known: assert property (@(negedge vsync) disable iff (!rst_n) !$isunknown({r, g, b}))
        else begin
            $error("colour output has unknown bits out of reset");
            failures++;
        end

    // Lit half of the hot planet is the same orange as class 1
    a_star_hidden: assert property (@(negedge vsync)
        (star_hit && disc_any && !(in_p1 && star_class == 2'd1)) |-> ({r, g, b} != star_rgb))
        else begin
            $error("star colour shows through a sun zone or planet disc");
            failures++;
        end

endmodule

bind color_compose space_bg_chk chk (
    .vsync        (space_bg_top.vsync),
    .rst_n        (space_bg_top.rst_n),
    .video_active (video_active),
    .in_sun       (in_sun),
    .in_corona    (in_corona),
    .in_p1        (in_p1),
    .in_p2        (in_p2),
    .in_p4        (in_p4),
    .star_hit     (star_hit),
    .star_class   (star_class),
    .r            (r),
    .g            (g),
    .b            (b)
);

`default_nettype wire

/* hdl/space_bg_top.sv */
// Top level of the space background: region decode, star field, colour compose
`default_nettype none
`timescale 1ns/1ns

module space_bg_top import space_bg_pkg::*; (
    input  logic   vsync,
    input  logic   rst_n,
    input  logic   video_active,
    input  coord_t pix_x,
    input  coord_t pix_y,
    output chan_t  r,
    output chan_t  g,
    output chan_t  b
);

    logic        in_sun;
    logic        in_corona;
    logic        in_halo1;
    logic        in_halo2;
    logic        in_p1;
    logic        in_p2;
    logic        in_p4;
    logic        star_hit;
    star_class_t star_class;

    body_region_decode u_region (
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .in_sun    (in_sun),
        .in_corona (in_corona),
        .in_halo1  (in_halo1),
        .in_halo2  (in_halo2),
        .in_p1     (in_p1),
        .in_p2     (in_p2),
        .in_p4     (in_p4)
    );

    // Only block with state
    star_field u_stars (
        .vsync      (vsync),
        .rst_n      (rst_n),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .star_hit   (star_hit),
        .star_class (star_class)
    );

    color_compose u_compose (
        .video_active (video_active),
        .pix_x        (pix_x),
        .pix_y        (pix_y),
        .in_sun       (in_sun),
        .in_corona    (in_corona),
        .in_halo1     (in_halo1),
        .in_halo2     (in_halo2),
        .in_p1        (in_p1),
        .in_p2        (in_p2),
        .in_p4        (in_p4),
        .star_hit     (star_hit),
        .star_class   (star_class),
        .r            (r),
        .g            (g),
        .b            (b)
    );

endmodule

`default_nettype wire

/* hdl/color_compose.sv */
// Colour composition: planet textures and priority select of the pixel colour
`default_nettype none
`timescale 1ns/1ns

module color_compose import space_bg_pkg::*; (
    input  logic        video_active,
    input  coord_t      pix_x,
    input  coord_t      pix_y,
    input  logic        in_sun,
    input  logic        in_corona,
    input  logic        in_halo1,
    input  logic        in_halo2,
    input  logic        in_p1,
    input  logic        in_p2,
    input  logic        in_p4,
    input  logic        star_hit,
    input  star_class_t star_class,
    output chan_t       r,
    output chan_t       g,
    output chan_t       b
);

    logic       on_screen;
    logic       p1_lit;
    logic [2:0] p2_noise;
    logic [2:0] p4_noise;
    chan_t      p1_g;
    chan_t      p2_b;
    chan_t      p4_g;

    // Coordinates past the XGA raster stay black
    assign on_screen = (pix_x < H_RES) && (pix_y < V_RES);

    // Hot planet: lit half faces the sun, split along the anti-diagonal
    assign p1_lit = (pix_x + pix_y) < (P1_X + P1_Y);
    assign p1_g   = p1_lit ? 2'd1 : 2'd0;

    // Earth-like ocean and land patches
    assign p2_noise = (pix_x[7:5] ^ pix_y[6:4]) + 3'(pix_x[4] ^ pix_y[5]);
    assign p2_b     = (p2_noise < 3'd3) ? 2'd0 : 2'd3;

    // Ice planet bands, mostly pale cyan
    assign p4_noise = (pix_x[6:4] ^ pix_y[5:3]) + 3'(pix_x[3] ^ pix_y[4]);
    assign p4_g     = (p4_noise < 3'd7) ? 2'd2 : 2'd1;

    always_comb begin
        if (!video_active || !on_screen) begin
            {r, g, b} = {2'd0, 2'd0, 2'd0};
        end else if (in_sun) begin
            {r, g, b} = {2'd3, 2'd2, 2'd0};
        end else if (in_corona) begin
            {r, g, b} = {2'd2, 2'd1, 2'd0};
        end else if (in_p1) begin
            {r, g, b} = {2'd3, p1_g, 2'd0};
        end else if (in_p2) begin
            {r, g, b} = {2'd0, 2'd1, p2_b};
        end else if (in_p4) begin
            {r, g, b} = {2'd0, p4_g, p4_g};
        end else if (star_hit) begin
            case (star_class)
                2'd0:    {r, g, b} = {2'd3, 2'd3, 2'd3};
                2'd1:    {r, g, b} = {2'd3, 2'd1, 2'd0};
                default: {r, g, b} = {2'd1, 2'd2, 2'd3};
            endcase
        end else if (in_halo1) begin
            {r, g, b} = {2'd1, 2'd0, 2'd0};
        end else if (in_halo2) begin
            {r, g, b} = {2'd1, 2'd0, 2'd1};   // faint violet outer ring
        end else begin
            {r, g, b} = {2'd0, 2'd0, 2'd0};
        end
    end

endmodule

`default_nettype wire

/* hdl/star_field.sv */
// Star field: per-frame scroll and twinkle counters, star hit test and class
`default_nettype none
`timescale 1ns/1ns

module star_field import space_bg_pkg::*; (
    input  logic        vsync,
    input  logic        rst_n,
    input  coord_t      pix_x,
    input  coord_t      pix_y,
    output logic        star_hit,
    output star_class_t star_class
);

    scroll_t              scroll_pos;
    twinkle_t             twinkle;
    scroll_t              half_scroll;
    logic [NUM_STARS-1:0] match;

    // One step per frame
    always_ff @(posedge vsync or negedge rst_n) begin
        if (!rst_n) begin
            scroll_pos <= '0;
            twinkle    <= '0;
        end else begin
            scroll_pos <= scroll_pos + scroll_t'(SCROLL_STEP);
            twinkle    <= twinkle + twinkle_t'(1);
        end
    end

    // Stars drift at half the scroll rate
    assign half_scroll = scroll_pos >> 1;

    for (genvar j = 0; j < NUM_STARS; j++) begin : g_star
        coord_t   sx;
        twinkle_t phase;
        logic     near_x;
        logic     near_y;

        // Wraps off the left edge back in on the right
        assign sx = coord_t'((STAR_X[j] + H_RES - half_scroll) % H_RES);

        assign near_x = (pix_x + STAR_SIZE >= sx) && (pix_x <= sx + STAR_SIZE);
        assign near_y = (pix_y + STAR_SIZE >= STAR_Y[j]) &&
                        (pix_y <= STAR_Y[j] + STAR_SIZE);

        // Star is dark in the one frame of eight where its phase hits zero
        assign phase = twinkle_t'(j) + twinkle;

        assign match[j] = near_x && near_y && (phase != '0);
    end

    assign star_hit = |match;

    // Later entries override, so the highest matching index wins
    always_comb begin
        star_class = '0;
        for (int j = 0; j < NUM_STARS; j++) begin
            if (match[j]) begin
                star_class = STAR_CLASS[j];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/body_region_decode.sv */
// Region decode: sun zones and planet discs from squared distances
`default_nettype none
`timescale 1ns/1ns

module body_region_decode import space_bg_pkg::*; (
    input  coord_t pix_x,
    input  coord_t pix_y,
    output logic   in_sun,
    output logic   in_corona,
    output logic   in_halo1,
    output logic   in_halo2,
    output logic   in_p1,
    output logic   in_p2,
    output logic   in_p4
);

    function automatic coord_t abs_diff(input coord_t a, input coord_t b);
        return (a > b) ? a - b : b - a;
    endfunction

    // Widen before squaring so the product keeps all its bits
    function automatic dist_sq_t sq_sum(input coord_t dx, input coord_t dy);
        dist_sq_t wx;
        dist_sq_t wy;
        wx = dist_sq_t'(dx);
        wy = dist_sq_t'(dy);
        return wx * wx + wy * wy;
    endfunction

    function automatic dist_sq_t r_sq(input int r);
        return dist_sq_t'(r * r);
    endfunction

    coord_t   sun_dx;
    coord_t   sun_dy;
    coord_t   p1_dx;
    coord_t   p1_dy;
    coord_t   p2_dx;
    coord_t   p2_dy;
    coord_t   p4_dx;
    coord_t   p4_dy;
    dist_sq_t sun_d;
    dist_sq_t p1_d;
    dist_sq_t p2_d;
    dist_sq_t p4_d;

    assign sun_dx = abs_diff(pix_x, coord_t'(SUN_X));
    assign sun_dy = abs_diff(pix_y, coord_t'(SUN_Y));
    assign p1_dx  = abs_diff(pix_x, coord_t'(P1_X));
    assign p1_dy  = abs_diff(pix_y, coord_t'(P1_Y));
    assign p2_dx  = abs_diff(pix_x, coord_t'(P2_X));
    assign p2_dy  = abs_diff(pix_y, coord_t'(P2_Y));
    assign p4_dx  = abs_diff(pix_x, coord_t'(P4_X));
    assign p4_dy  = abs_diff(pix_y, coord_t'(P4_Y));

    assign sun_d = sq_sum(sun_dx, sun_dy);
    assign p1_d  = sq_sum(p1_dx, p1_dy);
    assign p2_d  = sq_sum(p2_dx, p2_dy);
    assign p4_d  = sq_sum(p4_dx, p4_dy);

    // Each ring is the annulus outside the next zone in
    assign in_sun    = (sun_d <= r_sq(SUN_R));
    assign in_corona = (sun_d <= r_sq(CORONA_R)) && (sun_d > r_sq(SUN_R));
    assign in_halo1  = (sun_d <= r_sq(HALO1_R)) && (sun_d > r_sq(CORONA_R));
    assign in_halo2  = (sun_d <= r_sq(HALO2_R)) && (sun_d > r_sq(HALO1_R));

    assign in_p1 = (p1_d <= r_sq(P1_R));
    assign in_p2 = (p2_d <= r_sq(P2_R));
    assign in_p4 = (p4_d <= r_sq(P4_R));

endmodule

`default_nettype wire

/* hdl/space_bg_pkg.sv */
// Vector types, scene geometry constants and the star table
`default_nettype none

package space_bg_pkg;

    // Widths that carry a meaning
    typedef logic [10:0] coord_t;
    typedef logic [21:0] dist_sq_t;
    typedef logic [1:0]  chan_t;
    typedef logic [1:0]  star_class_t;
    typedef logic [9:0]  scroll_t;
    typedef logic [2:0]  twinkle_t;

    // XGA screen
    localparam int H_RES = 1024;
    localparam int V_RES = 768;

    // Sun, corona and the two halo rings share one centre
    localparam int SUN_X    = 80;
    localparam int SUN_Y    = 80;
    localparam int SUN_R    = 112;
    localparam int CORONA_R = 128;
    localparam int HALO1_R  = 208;
    localparam int HALO2_R  = 256;

    // Hot planet
    localparam int P1_X = 192;
    localparam int P1_Y = 320;
    localparam int P1_R = 48;

    // Earth-like planet
    localparam int P2_X = 480;
    localparam int P2_Y = 224;
    localparam int P2_R = 64;

    // Ice planet
    localparam int P4_X = 928;
    localparam int P4_Y = 128;
    localparam int P4_R = 64;

    // Star motion
    localparam int NUM_STARS   = 8;
    localparam int STAR_SIZE   = 1;
    localparam int SCROLL_STEP = 5;

    // Unscrolled star positions
    localparam coord_t STAR_X [NUM_STARS] = '{
        11'd72,
        11'd196,
        11'd427,
        11'd622,
        11'd729,
        11'd924,
        11'd747,
        11'd374
    };

    localparam coord_t STAR_Y [NUM_STARS] = '{
        11'd89,
        11'd196,
        11'd142,
        11'd374,
        11'd267,
        11'd552,
        11'd444,
        11'd321
    };

    // Class cycles white, orange, blue
    localparam star_class_t STAR_CLASS [NUM_STARS] = '{
        2'd0, 2'd1, 2'd2, 2'd0, 2'd1, 2'd2, 2'd0, 2'd1
    };

endpackage

`default_nettype wire
